// File: design/bank_cfg_pkg.sv
/*
 * Geometry and data-width constants of the banked scratchpad
 */
`default_nettype none

package bank_cfg_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    // Narrow word matches one bank
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 64;
    localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
    localparam int unsigned WideStrbWidth   = WideDataWidth / 8;

    // A wide port spans this many adjacent banks
    localparam int unsigned NarrowPerWide = WideDataWidth / NarrowDataWidth;

    // ----------------------------------------
    // Default geometry
    // ----------------------------------------
    localparam int unsigned DefNumNarrowBanks = 4;
    localparam int unsigned DefNumWideBanks   = DefNumNarrowBanks / NarrowPerWide;
    // Word address inside one bank, 64 words deep
    localparam int unsigned BankAddrWidth     = 6;

endpackage

`default_nettype wire

// File: design/mem_req_pkg.sv
/*
 * Request payload structs for the narrow and wide memory ports
 */
`default_nettype none

package mem_req_pkg;

    // ----------------------------------------
    // Narrow request
    // ----------------------------------------
    // One bank word, addressed inside the port's own bank
    typedef struct packed {
        // Word address in the bank
        logic [bank_cfg_pkg::BankAddrWidth-1:0]   addr;
        // High for a write, low for a read
        logic                                     we;
        logic [bank_cfg_pkg::NarrowDataWidth-1:0] wdata;
        // One strobe bit per byte lane
        logic [bank_cfg_pkg::NarrowStrbWidth-1:0] be;
    } narrow_req_t;

    // ----------------------------------------
    // Wide request
    // ----------------------------------------
    // Same word address, applied to every bank of the group
    typedef struct packed {
        logic [bank_cfg_pkg::BankAddrWidth-1:0] addr;
        logic                                   we;
        // Lowest bank of the group takes the low half
        logic [bank_cfg_pkg::WideDataWidth-1:0] wdata;
        logic [bank_cfg_pkg::WideStrbWidth-1:0] be;
    } wide_req_t;

endpackage

`default_nettype wire

// File: design/req_fifo.sv
/*
 * Small circular request FIFO, payload type set by parameter
 */
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter int unsigned Depth = 2,
    parameter type payload_t = logic
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    // Write side
    input  wire logic     push_valid_i,
    output logic          push_ready_o,
    input  wire payload_t push_data_i,
    // Read side, head of the queue
    output logic          pop_valid_o,
    input  wire logic     pop_ready_i,
    output payload_t      pop_data_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    // Entry storage
    payload_t mem_q [Depth];

    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic push, pop;

    // Not full accepts, not empty presents
    assign push_ready_o = (count_q != CntWidth'(Depth));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    // ----------------------------------------
    // Pointers and fill count
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // Wrap at the last slot
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/wide_narrow_arbiter.sv
/*
 * Round-robin grant between narrow and wide request heads,
 * priority flips every cycle
 */
`timescale 1ns/1ps
`default_nettype none

module wide_narrow_arbiter #(
    parameter int unsigned NumNarrowBanks = bank_cfg_pkg::DefNumNarrowBanks,
    parameter int unsigned NumWideBanks   = bank_cfg_pkg::DefNumWideBanks
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    // Head valid of every port FIFO
    input  wire logic [NumNarrowBanks-1:0] narrow_valid_i,
    input  wire logic [NumWideBanks-1:0]   wide_valid_i,
    // Grants, used as pop ready of the FIFOs
    output logic      [NumNarrowBanks-1:0] narrow_grant_o,
    output logic      [NumWideBanks-1:0]   wide_grant_o
);

    import bank_cfg_pkg::*;

    // High while narrow ports hold priority
    logic prio_narrow_q;

    // Wide valid seen per bank
    logic [NumNarrowBanks-1:0] wide_valid_per_bank;
    // Any narrow valid inside a wide group
    logic [NumWideBanks-1:0]   narrow_valid_per_group;

    // ----------------------------------------
    // Priority toggle
    // ----------------------------------------
    // Starts at narrow after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_narrow_q <= 1'b1;
        end else begin
            prio_narrow_q <= ~prio_narrow_q;
        end
    end

    // ----------------------------------------
    // Valid fan-out and merge
    // ----------------------------------------
    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_wide_fanout
        // Bank b belongs to wide group b / NarrowPerWide
        assign wide_valid_per_bank[b] = wide_valid_i[b / NarrowPerWide];
    end

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_narrow_merge
        assign narrow_valid_per_group[g] = |narrow_valid_i[g*NarrowPerWide +: NarrowPerWide];
    end

    // ----------------------------------------
    // Grant computation
    // ----------------------------------------
    always_comb begin
        if (prio_narrow_q) begin
            // Narrow always wins, wide only into an idle group
            narrow_grant_o = '1;
            wide_grant_o   = ~narrow_valid_per_group;
        end else begin
            // Wide always wins, narrow only where no wide head covers it
            wide_grant_o   = '1;
            narrow_grant_o = ~wide_valid_per_bank;
        end
    end

endmodule

`default_nettype wire

// File: design/bank_mux.sv
/*
 * Steers granted narrow and wide requests into the banks and
 * routes registered read data back to the owning port
 */
`timescale 1ns/1ps
`default_nettype none

module bank_mux #(
    parameter int unsigned NumNarrowBanks = bank_cfg_pkg::DefNumNarrowBanks,
    parameter int unsigned NumWideBanks   = bank_cfg_pkg::DefNumWideBanks
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    // Granted heads, fire = head valid and grant
    input  wire logic [NumNarrowBanks-1:0] narrow_fire_i,
    input  wire mem_req_pkg::narrow_req_t [NumNarrowBanks-1:0] narrow_req_i,
    input  wire logic [NumWideBanks-1:0] wide_fire_i,
    input  wire mem_req_pkg::wide_req_t [NumWideBanks-1:0] wide_req_i,
    // Bank side
    output logic [NumNarrowBanks-1:0] bank_en_o,
    output logic [NumNarrowBanks-1:0] bank_we_o,
    output logic [NumNarrowBanks-1:0][bank_cfg_pkg::BankAddrWidth-1:0] bank_addr_o,
    output logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowDataWidth-1:0] bank_wdata_o,
    output logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowStrbWidth-1:0] bank_be_o,
    input  wire logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowDataWidth-1:0] bank_rdata_i,
    // Responses
    output logic [NumNarrowBanks-1:0] narrow_rsp_valid_o,
    output logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowDataWidth-1:0] narrow_rsp_rdata_o,
    output logic [NumWideBanks-1:0] wide_rsp_valid_o,
    output logic [NumWideBanks-1:0][bank_cfg_pkg::WideDataWidth-1:0] wide_rsp_rdata_o
);

    import bank_cfg_pkg::*;

    // Read owners of the access in flight
    logic [NumNarrowBanks-1:0] narrow_rd_q;
    logic [NumWideBanks-1:0]   wide_rd_q;

    // ----------------------------------------
    // Request steering per bank
    // ----------------------------------------
    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_bank
        localparam int unsigned G = b / NarrowPerWide;
        // Slice of the wide word that lands in this bank
        localparam int unsigned S = b % NarrowPerWide;

        always_comb begin
            if (wide_fire_i[G]) begin
                bank_en_o[b]    = 1'b1;
                bank_we_o[b]    = wide_req_i[G].we;
                bank_addr_o[b]  = wide_req_i[G].addr;
                bank_wdata_o[b] = wide_req_i[G].wdata[S*NarrowDataWidth +: NarrowDataWidth];
                bank_be_o[b]    = wide_req_i[G].be[S*NarrowStrbWidth +: NarrowStrbWidth];
            end else begin
                // Own narrow port, enable only when it fires
                bank_en_o[b]    = narrow_fire_i[b];
                bank_we_o[b]    = narrow_req_i[b].we;
                bank_addr_o[b]  = narrow_req_i[b].addr;
                bank_wdata_o[b] = narrow_req_i[b].wdata;
                bank_be_o[b]    = narrow_req_i[b].be;
            end
        end
    end

    // ----------------------------------------
    // Read owner tracking
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            narrow_rd_q <= '0;
            wide_rd_q   <= '0;
        end else begin
            for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
                narrow_rd_q[i] <= narrow_fire_i[i] & ~narrow_req_i[i].we;
            end
            for (int unsigned j = 0; j < NumWideBanks; j++) begin
                wide_rd_q[j] <= wide_fire_i[j] & ~wide_req_i[j].we;
            end
        end
    end

    // Responses one cycle after the grant
    assign narrow_rsp_valid_o = narrow_rd_q;
    assign narrow_rsp_rdata_o = bank_rdata_i;
    assign wide_rsp_valid_o   = wide_rd_q;

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_wide_rsp
        // Lowest bank of the group ends up in the low half
        assign wide_rsp_rdata_o[g] = bank_rdata_i[g*NarrowPerWide +: NarrowPerWide];
    end

endmodule

`default_nettype wire

// File: design/sram_bank.sv
/*
 * Single-port narrow memory bank, byte strobes, one-cycle read
 */
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_ni,
    input  wire logic                                     en_i,
    input  wire logic                                     we_i,
    input  wire logic [bank_cfg_pkg::BankAddrWidth-1:0]   addr_i,
    input  wire logic [bank_cfg_pkg::NarrowDataWidth-1:0] wdata_i,
    input  wire logic [bank_cfg_pkg::NarrowStrbWidth-1:0] be_i,
    output logic      [bank_cfg_pkg::NarrowDataWidth-1:0] rdata_o
);

    import bank_cfg_pkg::*;

    localparam int unsigned NumWords = 2 ** BankAddrWidth;

    logic [NarrowDataWidth-1:0] mem_q [NumWords];

    // Strobed write, only enabled lanes change
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int unsigned i = 0; i < NarrowStrbWidth; i++) begin
                if (be_i[i]) begin
                    mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // Read data captured on a read enable, held otherwise
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (en_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: design/banked_mem_top.sv
/*
 * Banked scratchpad top level with narrow and wide request ports
 */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_top #(
    parameter int unsigned NumNarrowBanks = bank_cfg_pkg::DefNumNarrowBanks,
    parameter int unsigned NumWideBanks   = bank_cfg_pkg::DefNumWideBanks,
    parameter int unsigned Depth          = 2
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    // Narrow request and response ports
    input  wire logic [NumNarrowBanks-1:0] narrow_req_valid_i,
    output logic      [NumNarrowBanks-1:0] narrow_req_ready_o,
    input  wire logic [NumNarrowBanks-1:0][bank_cfg_pkg::BankAddrWidth-1:0] narrow_req_addr_i,
    input  wire logic [NumNarrowBanks-1:0] narrow_req_we_i,
    input  wire logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowDataWidth-1:0] narrow_req_wdata_i,
    input  wire logic [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowStrbWidth-1:0] narrow_req_be_i,
    output logic      [NumNarrowBanks-1:0] narrow_rsp_valid_o,
    output logic      [NumNarrowBanks-1:0][bank_cfg_pkg::NarrowDataWidth-1:0] narrow_rsp_rdata_o,
    // Wide request and response ports
    input  wire logic [NumWideBanks-1:0] wide_req_valid_i,
    output logic      [NumWideBanks-1:0] wide_req_ready_o,
    input  wire logic [NumWideBanks-1:0][bank_cfg_pkg::BankAddrWidth-1:0] wide_req_addr_i,
    input  wire logic [NumWideBanks-1:0] wide_req_we_i,
    input  wire logic [NumWideBanks-1:0][bank_cfg_pkg::WideDataWidth-1:0] wide_req_wdata_i,
    input  wire logic [NumWideBanks-1:0][bank_cfg_pkg::WideStrbWidth-1:0] wide_req_be_i,
    output logic      [NumWideBanks-1:0] wide_rsp_valid_o,
    output logic      [NumWideBanks-1:0][bank_cfg_pkg::WideDataWidth-1:0] wide_rsp_rdata_o
);

    import bank_cfg_pkg::*;
    import mem_req_pkg::*;

    // FIFO inputs and heads
    narrow_req_t [NumNarrowBanks-1:0] narrow_push_data, narrow_head;
    wide_req_t   [NumWideBanks-1:0]   wide_push_data, wide_head;
    logic [NumNarrowBanks-1:0] narrow_head_valid, narrow_grant, narrow_fire;
    logic [NumWideBanks-1:0]   wide_head_valid, wide_grant, wide_fire;

    // Bank wires
    logic [NumNarrowBanks-1:0] bank_en, bank_we;
    logic [NumNarrowBanks-1:0][BankAddrWidth-1:0]   bank_addr;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_wdata, bank_rdata;
    logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0] bank_be;

    // ----------------------------------------
    // Port FIFOs
    // ----------------------------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_narrow_port
        assign narrow_push_data[i] = '{addr: narrow_req_addr_i[i], we: narrow_req_we_i[i],
                                       wdata: narrow_req_wdata_i[i], be: narrow_req_be_i[i]};
        req_fifo #(.Depth(Depth), .payload_t(narrow_req_t)) i_fifo (
            .clk_i, .rst_ni,
            .push_valid_i(narrow_req_valid_i[i]), .push_ready_o(narrow_req_ready_o[i]),
            .push_data_i (narrow_push_data[i]),
            .pop_valid_o (narrow_head_valid[i]), .pop_ready_i(narrow_grant[i]),
            .pop_data_o  (narrow_head[i])
        );
    end

    for (genvar j = 0; j < NumWideBanks; j++) begin : gen_wide_port
        assign wide_push_data[j] = '{addr: wide_req_addr_i[j], we: wide_req_we_i[j],
                                     wdata: wide_req_wdata_i[j], be: wide_req_be_i[j]};
        req_fifo #(.Depth(Depth), .payload_t(wide_req_t)) i_fifo (
            .clk_i, .rst_ni,
            .push_valid_i(wide_req_valid_i[j]), .push_ready_o(wide_req_ready_o[j]),
            .push_data_i (wide_push_data[j]),
            .pop_valid_o (wide_head_valid[j]), .pop_ready_i(wide_grant[j]),
            .pop_data_o  (wide_head[j])
        );
    end

    // A head leaves its FIFO when valid and granted
    assign narrow_fire = narrow_head_valid & narrow_grant;
    assign wide_fire   = wide_head_valid & wide_grant;

    // ----------------------------------------
    // Arbitration, steering and banks
    // ----------------------------------------
    wide_narrow_arbiter #(.NumNarrowBanks(NumNarrowBanks), .NumWideBanks(NumWideBanks)) i_arb (
        .clk_i, .rst_ni,
        .narrow_valid_i(narrow_head_valid), .wide_valid_i(wide_head_valid),
        .narrow_grant_o(narrow_grant),      .wide_grant_o(wide_grant)
    );

    bank_mux #(.NumNarrowBanks(NumNarrowBanks), .NumWideBanks(NumWideBanks)) i_mux (
        .clk_i, .rst_ni,
        .narrow_fire_i(narrow_fire), .narrow_req_i(narrow_head),
        .wide_fire_i(wide_fire),     .wide_req_i(wide_head),
        .bank_en_o(bank_en), .bank_we_o(bank_we), .bank_addr_o(bank_addr),
        .bank_wdata_o(bank_wdata), .bank_be_o(bank_be), .bank_rdata_i(bank_rdata),
        .narrow_rsp_valid_o, .narrow_rsp_rdata_o, .wide_rsp_valid_o, .wide_rsp_rdata_o
    );

    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_bank
        sram_bank i_bank (
            .clk_i, .rst_ni,
            .en_i(bank_en[b]), .we_i(bank_we[b]), .addr_i(bank_addr[b]),
            .wdata_i(bank_wdata[b]), .be_i(bank_be[b]), .rdata_o(bank_rdata[b])
        );
    end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
/*
 * Testbench clock (4 ns) and reset (3 cycles) generator
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // Free-running clock, 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset low for 3 cycles, released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_banked_mem.sv
/*
 * Banked scratchpad testbench with reference memory, LFSR stimulus,
 * response checker and directed plus contention tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_banked_mem;

    import bank_cfg_pkg::*;

    localparam int unsigned NumN      = DefNumNarrowBanks;
    localparam int unsigned NumW      = DefNumWideBanks;
    localparam int unsigned NumPorts  = NumN + NumW;
    localparam int unsigned WaitLimit = 200;

    logic clk_i, rst_ni;
    logic [NumN-1:0] narrow_req_valid, narrow_req_ready, narrow_req_we, narrow_rsp_valid;
    logic [NumN-1:0][BankAddrWidth-1:0]   narrow_req_addr;
    logic [NumN-1:0][NarrowDataWidth-1:0] narrow_req_wdata, narrow_rsp_rdata;
    logic [NumN-1:0][NarrowStrbWidth-1:0] narrow_req_be;
    logic [NumW-1:0] wide_req_valid, wide_req_ready, wide_req_we, wide_rsp_valid;
    logic [NumW-1:0][BankAddrWidth-1:0] wide_req_addr;
    logic [NumW-1:0][WideDataWidth-1:0] wide_req_wdata, wide_rsp_rdata;
    logic [NumW-1:0][WideStrbWidth-1:0] wide_req_be;

    // Reference banks, one narrow word per entry
    logic [NarrowDataWidth-1:0] ref_mem [NumN][2**BankAddrWidth];
    // Expected read data per port, narrow ports first, then wide
    logic [63:0] exp_data [NumPorts][64];
    int unsigned exp_wr [NumPorts];
    int unsigned exp_rd [NumPorts];
    int unsigned stall_cnt;
    logic [15:0] lfsr_q;
    string test_name;

    tb_clk_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

    banked_mem_top #(.NumNarrowBanks(NumN), .NumWideBanks(NumW), .Depth(2)) u_dut (
        .clk_i, .rst_ni,
        .narrow_req_valid_i(narrow_req_valid), .narrow_req_ready_o(narrow_req_ready),
        .narrow_req_addr_i(narrow_req_addr), .narrow_req_we_i(narrow_req_we),
        .narrow_req_wdata_i(narrow_req_wdata), .narrow_req_be_i(narrow_req_be),
        .narrow_rsp_valid_o(narrow_rsp_valid), .narrow_rsp_rdata_o(narrow_rsp_rdata),
        .wide_req_valid_i(wide_req_valid), .wide_req_ready_o(wide_req_ready),
        .wide_req_addr_i(wide_req_addr), .wide_req_we_i(wide_req_we),
        .wide_req_wdata_i(wide_req_wdata), .wide_req_be_i(wide_req_be),
        .wide_rsp_valid_o(wide_rsp_valid), .wide_rsp_rdata_o(wide_rsp_rdata)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[62:0], fb};
        end
        return r;
    endfunction

    // Applies a strobed write or returns read data
    // Wide port g covers banks g*NarrowPerWide upward, low half in the lowest bank
    function automatic logic [63:0] ref_access(input bit wide, input int port,
            input logic [5:0] addr, input bit we, input logic [63:0] wdata,
            input logic [7:0] be);
        int nb;
        int base;
        logic [63:0] rd;
        nb   = wide ? NarrowPerWide : 1;
        base = wide ? port * NarrowPerWide : port;
        rd   = '0;
        for (int s = 0; s < nb; s++) begin
            for (int k = 0; k < NarrowStrbWidth; k++) begin
                if (we && be[s*NarrowStrbWidth + k]) begin
                    ref_mem[base+s][addr][k*8 +: 8] = wdata[s*NarrowDataWidth + k*8 +: 8];
                end
            end
            rd[s*NarrowDataWidth +: NarrowDataWidth] = ref_mem[base+s][addr];
        end
        return rd;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH test=%s expected=%h actual=%h", test_name, exp, act);
            $display("Test failed");
            $fatal(1, "simulation stopped on mismatch");
        end
    endtask

    // Drives one request, holds it until accepted, records expected read data
    task automatic send_req(input bit wide, input int port, input logic [5:0] addr,
            input bit we, input logic [63:0] wdata, input logic [7:0] be);
        int unsigned waited;
        int p;
        logic rdy;
        logic [63:0] rd;
        waited = 0;
        p      = wide ? NumN + port : port;
        @(posedge clk_i);
        if (wide) begin
            wide_req_valid[port] <= 1'b1;
            wide_req_addr[port]  <= addr;
            wide_req_we[port]    <= we;
            wide_req_wdata[port] <= wdata;
            wide_req_be[port]    <= be;
        end else begin
            narrow_req_valid[port] <= 1'b1;
            narrow_req_addr[port]  <= addr;
            narrow_req_we[port]    <= we;
            narrow_req_wdata[port] <= wdata[31:0];
            narrow_req_be[port]    <= be[3:0];
        end
        rdy = 1'b0;
        // Handshake decided mid-cycle, transfer on the next rising edge
        while (!rdy) begin
            @(negedge clk_i);
            rdy = wide ? wide_req_ready[port] : narrow_req_ready[port];
            if (!rdy) begin
                stall_cnt++;
                waited++;
                if (waited > WaitLimit) begin
                    fail_now($sformatf("request on port %0d was never accepted", p));
                end
            end
        end
        rd = ref_access(wide, port, addr, we, wdata, be);
        if (!we) begin
            exp_data[p][exp_wr[p] % 64] = rd;
            exp_wr[p]++;
        end
    endtask

    task automatic release_port(input bit wide, input int port);
        @(posedge clk_i);
        if (wide) begin
            wide_req_valid[port] <= 1'b0;
        end else begin
            narrow_req_valid[port] <= 1'b0;
        end
    endtask

    task automatic read_burst(input bit wide, input int port, input int n);
        for (int i = 0; i < n; i++) begin
            send_req(wide, port, 6'(rand_bits(4)), 1'b0, '0, '0);
        end
        release_port(wide, port);
    endtask

    // Waits until every port has returned all its read responses
    task automatic drain();
        int unsigned waited;
        for (int p = 0; p < NumPorts; p++) begin
            waited = 0;
            while (exp_rd[p] != exp_wr[p]) begin
                @(negedge clk_i);
                waited++;
                if (waited > WaitLimit) begin
                    fail_now($sformatf("port %0d is missing read responses", p));
                end
            end
        end
    endtask

    // ----------------------------------------
    // Response checker
    // ----------------------------------------
    always @(negedge clk_i) begin : check_rsp
        logic valid;
        logic [63:0] data;
        if (rst_ni) begin
            for (int p = 0; p < NumPorts; p++) begin
                if (p < NumN) begin
                    valid = narrow_rsp_valid[p];
                    data  = {32'b0, narrow_rsp_rdata[p]};
                end else begin
                    valid = wide_rsp_valid[p-NumN];
                    data  = wide_rsp_rdata[p-NumN];
                end
                if (valid) begin
                    if (exp_rd[p] == exp_wr[p]) begin
                        fail_now($sformatf("port %0d gave a response with no read pending", p));
                    end
                    check_value(exp_data[p][exp_rd[p] % 64], data);
                    exp_rd[p]++;
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main
        logic [5:0] addr;
        logic [7:0] be;
        int unsigned waited;
        lfsr_q           = 16'd84;
        stall_cnt        = 0;
        narrow_req_valid = '0;
        narrow_req_addr  = '0;
        narrow_req_we    = '0;
        narrow_req_wdata = '0;
        narrow_req_be    = '0;
        wide_req_valid   = '0;
        wide_req_addr    = '0;
        wide_req_we      = '0;
        wide_req_wdata   = '0;
        wide_req_be      = '0;
        for (int p = 0; p < NumPorts; p++) begin
            exp_wr[p] = 0;
            exp_rd[p] = 0;
        end

        // Idle after reset, every FIFO empty
        test_name = "reset";
        waited    = 0;
        while (rst_ni !== 1'b1) begin
            @(negedge clk_i);
            waited++;
            if (waited > WaitLimit) begin
                fail_now("reset was never released");
            end
        end
        repeat (4) begin
            @(negedge clk_i);
            check_value({NumN{1'b1}}, narrow_req_ready);
            check_value({NumW{1'b1}}, wide_req_ready);
            check_value('0, narrow_rsp_valid);
            check_value('0, wide_rsp_valid);
        end

        // Full write, partial overwrite, read back per bank
        test_name = "narrow_rw";
        for (int b = 0; b < NumN; b++) begin
            addr = 6'(rand_bits(6));
            send_req(1'b0, b, addr, 1'b1, rand_bits(32), 8'h0F);
            be = 8'(rand_bits(4));
            if (be == 8'h0F || be == 8'h00) begin
                be = 8'h06;
            end
            send_req(1'b0, b, addr, 1'b1, rand_bits(32), be);
            send_req(1'b0, b, addr, 1'b0, '0, '0);
            release_port(1'b0, b);
        end
        drain();

        // Wide write seen through narrow ports, and the reverse
        test_name = "wide_map";
        for (int g = 0; g < NumW; g++) begin
            addr = 6'(rand_bits(6));
            send_req(1'b1, g, addr, 1'b1, rand_bits(64), 8'hFF);
            send_req(1'b1, g, addr, 1'b0, '0, '0);
            release_port(1'b1, g);
            drain();
            for (int s = 0; s < NarrowPerWide; s++) begin
                send_req(1'b0, g*NarrowPerWide + s, addr, 1'b0, '0, '0);
                release_port(1'b0, g*NarrowPerWide + s);
            end
            drain();
            addr = addr ^ 6'h20;
            for (int s = 0; s < NarrowPerWide; s++) begin
                send_req(1'b0, g*NarrowPerWide + s, addr, 1'b1, rand_bits(32), 8'h0F);
                send_req(1'b0, g*NarrowPerWide + s, addr, 1'b0, '0, '0);
                release_port(1'b0, g*NarrowPerWide + s);
            end
            drain();
            send_req(1'b1, g, addr, 1'b0, '0, '0);
            release_port(1'b1, g);
            drain();
        end

        // Preload the lowest 16 words of every bank
        test_name = "preload";
        for (int b = 0; b < NumN; b++) begin
            for (int a = 0; a < 16; a++) begin
                send_req(1'b0, b, 6'(a), 1'b1, rand_bits(32), 8'h0F);
            end
            send_req(1'b0, b, 6'd15, 1'b0, '0, '0);
            release_port(1'b0, b);
        end
        drain();

        // All ports read back to back on overlapping banks
        test_name = "contention";
        fork
            read_burst(1'b0, 0, 24);
            read_burst(1'b0, 1, 24);
            read_burst(1'b0, 2, 24);
            read_burst(1'b0, 3, 24);
            read_burst(1'b1, 0, 24);
            read_burst(1'b1, 1, 24);
        join
        drain();

        // Two ports on bank 0 fill their FIFOs
        test_name = "backpressure";
        stall_cnt = 0;
        fork
            read_burst(1'b0, 0, 16);
            read_burst(1'b1, 0, 16);
        join
        drain();

        if (stall_cnt == 0) begin
            fail_now("ready never dropped while two ports shared a bank");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/bank_cfg_pkg.sv
design/mem_req_pkg.sv
design/req_fifo.sv
design/wide_narrow_arbiter.sv
design/bank_mux.sv
design/sram_bank.sv
design/banked_mem_top.sv
tests/tb_clk_gen.sv
tests/tb_banked_mem.sv

// File: Bender.yml
package:
  name: banked_mem

sources:
  # Packages first, then the design from leaves to top
  - design/bank_cfg_pkg.sv
  - design/mem_req_pkg.sv
  - design/req_fifo.sv
  - design/wide_narrow_arbiter.sv
  - design/bank_mux.sv
  - design/sram_bank.sv
  - design/banked_mem_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_banked_mem.sv
